/* mem_system_settings.svh */
`ifndef MEM_SYSTEM_SETTINGS_SVH
`define MEM_SYSTEM_SETTINGS_SVH

// cycles from a bank access to valid read data
// a bank is also busy for this long after any access
`define MEM_LATENCY 4

// words per cache line, fixed by the address split
`define LINE_WORDS 4

// direct-mapped cache depth, one line per index
`define NUM_LINES 256

// main memory size in 16-bit words
// spread evenly over the four banks
`define MEM_WORDS 32768

`endif

/* mem_system_pkg.sv */
package mem_system_pkg;

   // cache view of a byte address
   typedef struct packed {
      logic [4:0] tag;
      logic [7:0] index;
      logic [2:0] offset;
   } cache_view_t;

   // bank view of the same address
   // consecutive words of a line land in consecutive banks
   typedef struct packed {
      logic [12:0] row;
      logic [1:0]  bank;
      logic        byte_sel;
   } bank_view_t;

   typedef union packed {
      cache_view_t cache_view;
      bank_view_t  bank_view;
   } mem_addr_u;

   // controller states
   typedef enum logic [2:0] {
      ST_IDLE       = 3'd0,
      ST_COMPARE    = 3'd1,
      ST_WRITE_BACK = 3'd2,
      ST_FILL       = 3'd3,
      ST_FILL_WAIT  = 3'd4,
      ST_FINISH     = 3'd5
   } ctrl_state_e;

endpackage

/* cache_array.sv */
`include "mem_system_settings.svh"

module cache_array (
   input  logic                      clk,
   input  logic                      arst_n,
   input  mem_system_pkg::mem_addr_u addr,
   input  logic [1:0]                word_sel,
   input  logic                      cache_en,
   input  logic                      cache_comp,
   input  logic                      cache_write,
   input  logic                      cache_valid_in,
   input  logic [15:0]               wdata,
   output logic [15:0]               rdata,
   output logic                      hit,
   output logic                      dirty,
   output logic                      valid,
   output logic [4:0]                victim_tag
);

   localparam int LINES = `NUM_LINES;
   localparam int WORDS = `LINE_WORDS;

   logic [LINES-1:0] valid_q;
   logic [LINES-1:0] dirty_q;
   logic [4:0]       tag_q  [LINES];
   logic [15:0]      data_q [LINES][WORDS];

   logic [7:0] idx;
   logic       tag_match;
   logic       do_write;

   assign idx = addr.cache_view.index;

   // line status, read combinationally
   assign valid      = valid_q[idx];
   assign dirty      = dirty_q[idx];
   assign victim_tag = tag_q[idx];
   assign tag_match  = (tag_q[idx] == addr.cache_view.tag);
   assign hit        = cache_en & cache_comp & valid_q[idx] & tag_match;
   assign rdata      = data_q[idx][word_sel];

   // a compared write only lands on a hit
   assign do_write = cache_en & cache_write & (hit | ~cache_comp);

   always_ff @(posedge clk or negedge arst_n) begin
      if (!arst_n) begin
         valid_q <= '0;
         dirty_q <= '0;
      end else if (do_write) begin
         if (cache_comp) begin
            dirty_q[idx] <= 1'b1;
         end else begin
            // fill write, the line now matches memory
            valid_q[idx] <= cache_valid_in;
            dirty_q[idx] <= 1'b0;
         end
      end
   end

   always_ff @(posedge clk) begin
      if (do_write) begin
         data_q[idx][word_sel] <= wdata;
         if (!cache_comp) begin
            tag_q[idx] <= addr.cache_view.tag;
         end
      end
   end

endmodule

/* banked_mem.sv */
`include "mem_system_settings.svh"

module banked_mem (
   input  logic                      clk,
   input  logic                      arst_n,
   input  mem_system_pkg::mem_addr_u mem_addr,
   input  logic                      mem_rd,
   input  logic                      mem_wr,
   input  logic [15:0]               wdata,
   output logic [15:0]               mem_rdata,
   output logic                      mem_rvalid,
   output logic [3:0]                bank_busy
);

   localparam int LAT       = `MEM_LATENCY;
   localparam int BANK_ROWS = `MEM_WORDS / 4;
   localparam int CNT_W     = $clog2(LAT + 1);

   logic [15:0]      bank_mem [4][BANK_ROWS];
   logic [CNT_W-1:0] busy_cnt [4];
   logic [15:0]      rd_data_pipe [LAT];
   logic [LAT-1:0]   rd_vld_pipe;

   // memory contents start cleared in simulation
   initial begin
      for (int b = 0; b < 4; b++) begin
         for (int r = 0; r < BANK_ROWS; r++) begin
            bank_mem[b][r] = '0;
         end
      end
   end

   always @(posedge clk) begin
      if (mem_wr) begin
         bank_mem[mem_addr.bank_view.bank][mem_addr.bank_view.row] <= wdata;
      end
   end

   // per-bank busy countdown
   for (genvar b = 0; b < 4; b++) begin : g_bank
      always_ff @(posedge clk or negedge arst_n) begin
         if (!arst_n) begin
            busy_cnt[b] <= '0;
         end else if ((mem_rd || mem_wr) && (mem_addr.bank_view.bank == 2'(b))) begin
            busy_cnt[b] <= CNT_W'(LAT - 1);
         end else if (busy_cnt[b] != '0) begin
            busy_cnt[b] <= busy_cnt[b] - 1'b1;
         end
      end
      assign bank_busy[b] = (busy_cnt[b] != '0);
   end

   // read return pipe, one slot per cycle of latency
   always_ff @(posedge clk) begin
      rd_data_pipe[0] <= bank_mem[mem_addr.bank_view.bank][mem_addr.bank_view.row];
      for (int s = 1; s < LAT; s++) begin
         rd_data_pipe[s] <= rd_data_pipe[s-1];
      end
   end

   always_ff @(posedge clk or negedge arst_n) begin
      if (!arst_n) begin
         rd_vld_pipe <= '0;
      end else begin
         rd_vld_pipe[0] <= mem_rd;
         for (int s = 1; s < LAT; s++) begin
            rd_vld_pipe[s] <= rd_vld_pipe[s-1];
         end
      end
   end

   assign mem_rdata  = rd_data_pipe[LAT-1];
   assign mem_rvalid = rd_vld_pipe[LAT-1];

endmodule

/* cache_ctrl.sv */
`include "mem_system_settings.svh"

module cache_ctrl (
   input  logic        clk,
   input  logic        arst_n,
   input  logic [15:0] addr,
   input  logic        rd,
   input  logic        wr,
   input  logic        hit,
   input  logic        dirty,
   input  logic        valid,
   input  logic [4:0]  victim_tag,
   input  logic [3:0]  bank_busy,
   input  logic        mem_rvalid,
   output logic        cache_en,
   output logic        cache_comp,
   output logic        cache_write,
   output logic        cache_valid_in,
   output logic        fill_sel,
   output logic [1:0]  word_sel,
   output logic        mem_rd,
   output logic        mem_wr,
   output logic [15:0] mem_addr,
   output logic        done,
   output logic        stall,
   output logic        cache_hit,
   output logic        err
);

   import mem_system_pkg::*;

   localparam logic [1:0] LAST_WORD = 2'(`LINE_WORDS - 1);

   ctrl_state_e state;
   ctrl_state_e state_nxt;
   mem_addr_u   req_addr;
   mem_addr_u   line_addr;
   logic        req_wr;
   logic [4:0]  wb_tag;
   logic [1:0]  issue_cnt;
   logic [1:0]  fill_cnt;
   logic        strobe;
   logic        bad_req;
   logic        accept;
   logic        issue_ok;
   logic        fill_we;

   assign strobe  = rd | wr;
   assign bad_req = addr[0] | (rd & wr);
   assign accept  = (state == ST_IDLE) & strobe & ~bad_req;

   // one word per cycle, only to a bank that is free
   assign issue_ok = ((state == ST_WRITE_BACK) | (state == ST_FILL)) & ~bank_busy[issue_cnt];
   assign fill_sel = (state == ST_FILL) | (state == ST_FILL_WAIT);
   assign fill_we  = fill_sel & mem_rvalid;

   assign mem_wr         = issue_ok & (state == ST_WRITE_BACK);
   assign mem_rd         = issue_ok & (state == ST_FILL);
   assign cache_valid_in = fill_we;
   assign stall          = (state != ST_IDLE);

   // line address for both cache and memory, victim tag during write-back
   always_comb begin
      line_addr = req_addr;
      line_addr.cache_view.offset = {issue_cnt, 1'b0};
      if (state == ST_WRITE_BACK) begin
         line_addr.cache_view.tag = wb_tag;
      end
   end
   assign mem_addr = line_addr;

   always_comb begin
      state_nxt   = state;
      cache_en    = 1'b0;
      cache_comp  = 1'b0;
      cache_write = 1'b0;
      word_sel    = req_addr.cache_view.offset[2:1];
      done        = 1'b0;
      cache_hit   = 1'b0;
      case (state)
         ST_IDLE: begin
            if (accept) state_nxt = ST_COMPARE;
         end
         ST_COMPARE: begin
            cache_en    = 1'b1;
            cache_comp  = 1'b1;
            cache_write = req_wr;
            if (hit) begin
               done      = 1'b1;
               cache_hit = 1'b1;
               state_nxt = ST_IDLE;
            end else if (valid && dirty) begin
               state_nxt = ST_WRITE_BACK;
            end else begin
               state_nxt = ST_FILL;
            end
         end
         ST_WRITE_BACK: begin
            // victim word goes straight from cache to memory
            cache_en = 1'b1;
            word_sel = issue_cnt;
            if (issue_ok && issue_cnt == LAST_WORD) state_nxt = ST_FILL;
         end
         ST_FILL: begin
            if (issue_ok && issue_cnt == LAST_WORD) state_nxt = ST_FILL_WAIT;
         end
         ST_FILL_WAIT: begin
            if (fill_we && fill_cnt == LAST_WORD) state_nxt = ST_FINISH;
         end
         ST_FINISH: begin
            // line is resident now, replay the request
            cache_en    = 1'b1;
            cache_comp  = 1'b1;
            cache_write = req_wr;
            done        = 1'b1;
            state_nxt   = ST_IDLE;
         end
         default: state_nxt = ST_IDLE;
      endcase
      // returning fill words are written as they arrive
      if (fill_we) begin
         cache_en    = 1'b1;
         cache_write = 1'b1;
         word_sel    = fill_cnt;
      end
   end

   always_ff @(posedge clk or negedge arst_n) begin
      if (!arst_n) begin
         state     <= ST_IDLE;
         issue_cnt <= '0;
         fill_cnt  <= '0;
         err       <= 1'b0;
      end else begin
         state <= state_nxt;
         err   <= (state == ST_IDLE) & strobe & bad_req;
         // counters wrap to zero at the end of each phase
         if (state == ST_COMPARE) begin
            issue_cnt <= '0;
            fill_cnt  <= '0;
         end else begin
            if (issue_ok) issue_cnt <= issue_cnt + 1'b1;
            if (fill_we) fill_cnt <= fill_cnt + 1'b1;
         end
      end
   end

   always_ff @(posedge clk) begin
      if (accept) begin
         req_addr <= addr;
         req_wr   <= wr;
      end
      if (state == ST_COMPARE) begin
         wb_tag <= victim_tag;
      end
   end

endmodule

/* mem_system.sv */
module mem_system (
   input  logic        clk,
   input  logic        arst_n,
   input  logic [15:0] addr,
   // data_in is held from the write strobe through done
   input  logic [15:0] data_in,
   input  logic        rd,
   input  logic        wr,
   output logic [15:0] data_out,
   output logic        done,
   output logic        stall,
   output logic        cache_hit,
   output logic        err
);

   import mem_system_pkg::*;

   logic        cache_en;
   logic        cache_comp;
   logic        cache_write;
   logic        cache_valid_in;
   logic        fill_sel;
   logic [1:0]  word_sel;
   logic        hit;
   logic        dirty;
   logic        valid;
   logic [4:0]  victim_tag;
   logic [15:0] cache_rdata;
   logic [15:0] cache_wdata;
   logic        mem_rd;
   logic        mem_wr;
   logic [15:0] mem_addr;
   logic [15:0] mem_rdata;
   logic        mem_rvalid;
   logic [3:0]  bank_busy;
   mem_addr_u   line_addr;

   // cache and memory share the latched line address
   assign line_addr   = mem_addr;
   assign cache_wdata = fill_sel ? mem_rdata : data_in;
   // reads are always served from the cache
   assign data_out    = cache_rdata;

   cache_array u_cache (
      .clk            (clk),
      .arst_n         (arst_n),
      .addr           (line_addr),
      .word_sel       (word_sel),
      .cache_en       (cache_en),
      .cache_comp     (cache_comp),
      .cache_write    (cache_write),
      .cache_valid_in (cache_valid_in),
      .wdata          (cache_wdata),
      .rdata          (cache_rdata),
      .hit            (hit),
      .dirty          (dirty),
      .valid          (valid),
      .victim_tag     (victim_tag)
   );

   banked_mem u_mem (
      .clk        (clk),
      .arst_n     (arst_n),
      .mem_addr   (line_addr),
      .mem_rd     (mem_rd),
      .mem_wr     (mem_wr),
      .wdata      (cache_rdata),
      .mem_rdata  (mem_rdata),
      .mem_rvalid (mem_rvalid),
      .bank_busy  (bank_busy)
   );

   cache_ctrl u_ctrl (
      .clk            (clk),
      .arst_n         (arst_n),
      .addr           (addr),
      .rd             (rd),
      .wr             (wr),
      .hit            (hit),
      .dirty          (dirty),
      .valid          (valid),
      .victim_tag     (victim_tag),
      .bank_busy      (bank_busy),
      .mem_rvalid     (mem_rvalid),
      .cache_en       (cache_en),
      .cache_comp     (cache_comp),
      .cache_write    (cache_write),
      .cache_valid_in (cache_valid_in),
      .fill_sel       (fill_sel),
      .word_sel       (word_sel),
      .mem_rd         (mem_rd),
      .mem_wr         (mem_wr),
      .mem_addr       (mem_addr),
      .done           (done),
      .stall          (stall),
      .cache_hit      (cache_hit),
      .err            (err)
   );

endmodule

/* mem_system_props.sv */
`include "mem_system_settings.svh"

module mem_system_props (
   input logic        clk,
   input logic        arst_n,
   input logic [15:0] addr,
   input logic [15:0] data_in,
   input logic        rd,
   input logic        wr,
   input logic [15:0] data_out,
   input logic        done,
   input logic        stall,
   input logic        cache_hit,
   input logic        err
);

   int unsigned fail_count = 0;

   logic [15:0]           shadow [`MEM_WORDS];
   logic [`NUM_LINES-1:0] res_valid;
   logic [4:0]            res_tag [`NUM_LINES];
   logic                  seen_strobe;
   logic                  pending;
   logic                  pend_rd;
   logic                  pend_hit;
   logic [15:0]           pend_addr;
   logic                  accept;
   logic                  bad_req;
   logic                  pred_hit;
   logic [15:0]           exp_rdata;

   assign accept    = (rd | wr) & ~stall & ~addr[0] & ~(rd & wr);
   assign bad_req   = (rd | wr) & ~stall & (addr[0] | (rd & wr));
   // line of this index holds the tag of the last legal request to it
   assign pred_hit  = res_valid[addr[10:3]] & (res_tag[addr[10:3]] == addr[15:11]);
   assign exp_rdata = shadow[pend_addr[15:1]];

   initial begin
      for (int w = 0; w < `MEM_WORDS; w++) begin
         shadow[w] = '0;
      end
   end

   always @(posedge clk) begin
      if (accept && wr) begin
         shadow[addr[15:1]] <= data_in;
      end
   end

   always_ff @(posedge clk or negedge arst_n) begin
      if (!arst_n) begin
         seen_strobe <= 1'b0;
         pending     <= 1'b0;
         res_valid   <= '0;
      end else begin
         if (rd || wr) begin
            seen_strobe <= 1'b1;
         end
         if (accept) begin
            pending               <= 1'b1;
            pend_rd               <= rd;
            pend_hit              <= pred_hit;
            pend_addr             <= addr;
            res_valid[addr[10:3]] <= 1'b1;
            res_tag[addr[10:3]]   <= addr[15:11];
         end else if (done) begin
            pending <= 1'b0;
         end
      end
   end

   idle_after_reset: assert property (@(posedge clk) disable iff (!arst_n)
      !seen_strobe |-> !done && !stall && !err)
   else begin
      $error("done, stall or err active after reset before any request");
      fail_count = fail_count + 1;
   end

   read_data: assert property (@(posedge clk) disable iff (!arst_n)
      done && pend_rd |-> data_out == exp_rdata)
   else begin
      $error("FAIL data_out got %h expected %h", $sampled(data_out), $sampled(exp_rdata));
      fail_count = fail_count + 1;
   end

   // hits finish right away, misses only stall
   first_cycle: assert property (@(posedge clk) disable iff (!arst_n)
      accept |=> stall && done == pend_hit)
   else begin
      $error("FAIL done got %h expected %h", $sampled(done), $sampled(pend_hit));
      fail_count = fail_count + 1;
   end

   stall_until_done: assert property (@(posedge clk) disable iff (!arst_n)
      pending |-> stall)
   else begin
      $error("stall dropped before the request finished");
      fail_count = fail_count + 1;
   end

   // free again right after done, and never busy after a rejected request
   stall_release: assert property (@(posedge clk) disable iff (!arst_n)
      done || bad_req |=> !stall)
   else begin
      $error("stall still high in the cycle after done or a rejected request");
      fail_count = fail_count + 1;
   end

   done_once: assert property (@(posedge clk) disable iff (!arst_n)
      done |-> pending)
   else begin
      $error("done raised with no request outstanding");
      fail_count = fail_count + 1;
   end

   hit_flag: assert property (@(posedge clk) disable iff (!arst_n)
      done |-> cache_hit == pend_hit)
   else begin
      $error("FAIL cache_hit got %h expected %h", $sampled(cache_hit), $sampled(pend_hit));
      fail_count = fail_count + 1;
   end

   err_pulse: assert property (@(posedge clk) disable iff (!arst_n)
      err == $past(bad_req))
   else begin
      $error("FAIL err got %h expected %h", $sampled(err), $past(bad_req));
      fail_count = fail_count + 1;
   end

   no_strobe_in_stall: assert property (@(posedge clk) disable iff (!arst_n)
      stall |-> !(rd || wr))
   else begin
      $error("request strobed while the system was stalled");
      fail_count = fail_count + 1;
   end

endmodule

bind mem_system mem_system_props u_props (
   .clk       (clk),
   .arst_n    (arst_n),
   .addr      (addr),
   .data_in   (data_in),
   .rd        (rd),
   .wr        (wr),
   .data_out  (data_out),
   .done      (done),
   .stall     (stall),
   .cache_hit (cache_hit),
   .err       (err)
);

/* tb_mem_system.sv */
`include "mem_system_settings.svh"

module tb_mem_system;

   localparam int          CLK_PER  = 40;
   localparam int          NUM_REQS = 300;
   localparam logic [31:0] SEED     = 32'h4f4e9760;
   // dirty miss worst case plus the gap between requests
   localparam int          REQ_CYC  = 8 + `MEM_LATENCY + 4 + 4;
   localparam int          TIMEOUT  = (NUM_REQS * REQ_CYC + 10 + 100) * CLK_PER;

   logic        clk;
   logic        arst_n;
   logic [15:0] addr;
   logic [15:0] data_in;
   logic        rd;
   logic        wr;
   logic [15:0] data_out;
   logic        done;
   logic        stall;
   logic        cache_hit;
   logic        err;

   mem_system u_dut (
      .clk       (clk),
      .arst_n    (arst_n),
      .addr      (addr),
      .data_in   (data_in),
      .rd        (rd),
      .wr        (wr),
      .data_out  (data_out),
      .done      (done),
      .stall     (stall),
      .cache_hit (cache_hit),
      .err       (err)
   );

   initial begin
      clk = 1'b0;
      forever #(CLK_PER / 2) clk = ~clk;
   end

   // few tags over three indices, so lines conflict and dirty victims are common
   function automatic logic [15:0] pick_addr();
      logic [4:0] tag;
      logic [7:0] index;
      logic [1:0] word;
      tag   = 5'($urandom % 4);
      index = 8'(($urandom % 3) * 85);
      word  = 2'($urandom % 4);
      return {tag, index, word, 1'b0};
   endfunction

   // one-cycle strobe, sent only once the system is idle
   task automatic issue_request(input logic do_rd, input logic do_wr,
                                input logic [15:0] a, input logic [15:0] d);
      @(negedge clk);
      while (stall) begin
         @(negedge clk);
      end
      @(posedge clk);
      rd      <= do_rd;
      wr      <= do_wr;
      addr    <= a;
      data_in <= d;
      @(posedge clk);
      rd <= 1'b0;
      wr <= 1'b0;
   endtask

   initial begin
      logic [15:0] a;
      logic [15:0] last_a;
      logic [15:0] d;
      int unsigned kind;
      void'($urandom(SEED));
      arst_n  = 1'b0;
      addr    = '0;
      data_in = '0;
      rd      = 1'b0;
      wr      = 1'b0;
      last_a  = '0;
      repeat (10) @(posedge clk);
      arst_n <= 1'b1;
      // idle gap so the post-reset check sees quiet outputs
      repeat (3) @(posedge clk);
      for (int n = 0; n < NUM_REQS; n++) begin
         kind = $urandom % 10;
         a    = (kind < 3) ? last_a : pick_addr();
         d    = 16'($urandom);
         if (kind == 9) begin
            if ($urandom % 2 == 0) begin
               issue_request(1'b1, 1'b0, a | 16'h0001, d);
            end else begin
               issue_request(1'b1, 1'b1, a, d);
            end
         end else begin
            issue_request(kind % 2 == 0, kind % 2 == 1, a, d);
            last_a = a;
         end
      end
      @(negedge clk);
      while (stall) begin
         @(negedge clk);
      end
      repeat (2) @(negedge clk);
      if (u_dut.u_props.fail_count == 0) begin
         $display("ALL CHECKS PASSED");
         $finish;
      end else begin
         $display("CHECKS FAILED");
         $fatal(1, "property checker reported failures");
      end
   end

   // first assertion failure ends the run
   always @(negedge clk) begin
      if (u_dut.u_props.fail_count != 0) begin
         $display("CHECKS FAILED");
         $fatal(1, "an assertion in the property checker failed");
      end
   end

   initial begin
      #(TIMEOUT);
      $display("timeout, the requests did not finish within %0d time units", TIMEOUT);
      $display("CHECKS FAILED");
      $fatal(1, "watchdog expired");
   end

endmodule

/* mem_system.f */
+incdir+.
mem_system_pkg.sv
cache_array.sv
banked_mem.sv
cache_ctrl.sv
mem_system.sv
mem_system_props.sv
tb_mem_system.sv

/* Makefile */
VERILATOR ?= verilator
TOP       ?= tb_mem_system
FILELIST  ?= mem_system.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
ERR_LIMIT ?= 100
VFLAGS    ?= --binary --timing --assert
FAIL_MSG  ?= CHECKS FAILED
PASS_MSG  ?= ALL CHECKS PASSED

SOURCES := $(FILELIST) $(wildcard *.sv) $(wildcard *.svh)
SIM     := $(OBJ_DIR)/V$(TOP)

.PHONY: all compile run clean

all: run

compile: $(SIM)

$(SIM): $(SOURCES)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: $(SIM)
	-./$(SIM) +verilator+error+limit+$(ERR_LIMIT) 2>&1 | tee $(LOG)
	@if grep -q "$(FAIL_MSG)" $(LOG); then echo "simulation failed, see $(LOG)"; exit 1; fi
	@grep -q "$(PASS_MSG)" $(LOG) || { echo "simulation ended early, see $(LOG)"; exit 1; }

clean:
	rm -rf $(OBJ_DIR) $(LOG)
